// File: verilog/hist_geom_pkg.sv
//********************
// window geometry and config register map; values are inclusive minus-one sizes
//********************
package hist_geom_pkg;

    // left, top, width-1 and height-1 all share this width
    localparam int coord_w = 16;

    // cfg_data_i holds {top, left} or {height_m1, width_m1}
    localparam logic cfg_addr_left_top     = 1'b0;
    localparam logic cfg_addr_width_height = 1'b1;

    // colour phase at first pixel of first line, {line bit, pixel bit}
    localparam logic [1:0] bayer_xor = 2'b00;

endpackage

// File: verilog/hist_bin_pkg.sv
//********************
// bin index is {colour, pixel}; counts wrap at 32 bits
//********************
package hist_bin_pkg;

    localparam int pixel_w    = 8;
    localparam int color_w    = 2;
    localparam int bin_addr_w = color_w + pixel_w; // 10
    localparam int num_bins   = 1 << bin_addr_w;   // 1024
    localparam int count_w    = 32;

    // cycles between woi_done and readout, matches accumulator depth
    localparam int drain_cycles = 3;

    typedef struct packed {
        logic [color_w-1:0] color; // bayer phase, 0 in mono
        logic [pixel_w-1:0] pixel; // raw pixel value
    } bin_fields_t;

    // same 10 bits seen as fields or as a flat index
    typedef union packed {
        bin_fields_t           fields;
        logic [bin_addr_w-1:0] index;
    } bin_addr_u;

endpackage

// File: verilog/hist_ctrl.sv
//********************
// frame sequencing; one frame in flight, sof ignored while busy
//********************
module hist_ctrl
    import hist_bin_pkg::*;
(
    input  logic pclk,
    input  logic hist_rst_pclk,
    input  logic hist_en_i,
    input  logic sof_i,
    input  logic woi_done_i,
    input  logic sweep_done_i,
    output logic frame_arm_o,
    output logic sweep_start_o,
    output logic sweep_emit_o,
    output logic hist_busy_o
);
    localparam logic [2:0] st_clear    = 3'd0; // silent clear after reset
    localparam logic [2:0] st_idle     = 3'd1;
    localparam logic [2:0] st_armed    = 3'd2; // waiting for sof
    localparam logic [2:0] st_counting = 3'd3;
    localparam logic [2:0] st_drain    = 3'd4; // let accumulator writes land
    localparam logic [2:0] st_readout  = 3'd5;

    logic [2:0]                         state;
    logic                               sweep_run; // sweep issued, waiting for done
    logic [$clog2(drain_cycles+1)-1:0]  drain_cnt;

    assign frame_arm_o   = (state == st_armed);
    assign sweep_emit_o  = (state == st_readout);
    assign sweep_start_o = (state == st_clear || state == st_readout) && !sweep_run;
    assign hist_busy_o   = !(state == st_idle || state == st_armed);

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            state     <= st_clear;
            sweep_run <= 1'b0;
            drain_cnt <= '0;
        end else begin
            if (sweep_start_o)     sweep_run <= 1'b1;
            else if (sweep_done_i) sweep_run <= 1'b0;

            case (state)
                st_clear:    if (sweep_done_i) state <= st_idle;
                st_idle:     if (hist_en_i) state <= st_armed; // graceful, only between frames
                st_armed: begin
                    if (sof_i)           state <= st_counting; // window opens on same sof
                    else if (!hist_en_i) state <= st_idle;
                end
                st_counting: begin
                    if (woi_done_i) begin
                        state     <= st_drain;
                        drain_cnt <= '0;
                    end
                end
                st_drain: begin
                    if (drain_cnt == drain_cycles - 1) state <= st_readout;
                    else                               drain_cnt <= drain_cnt + 1'b1;
                end
                st_readout:  if (sweep_done_i) state <= st_idle;
                default:     state <= st_idle;
            endcase
        end
    end

endmodule

// File: verilog/hist_window.sv
//********************
// needs idle cycles between lines; window beyond line length just clips
//********************
module hist_window
    import hist_geom_pkg::*;
    import hist_bin_pkg::*;
(
    input  logic                 pclk,
    input  logic                 hist_rst_pclk,
    input  logic                 cfg_we_i,
    input  logic                 cfg_addr_i,
    input  logic [2*coord_w-1:0] cfg_data_i,
    input  logic                 sof_i,
    input  logic                 hact_i,
    input  logic [pixel_w-1:0]   pixel_i,
    input  logic                 monochrome_i,
    input  logic                 frame_arm_i,
    output logic                 pix_valid_o,
    output bin_addr_u            pix_addr_o,
    output logic                 woi_done_o
);
    logic [coord_w-1:0] left;
    logic [coord_w-1:0] top;
    logic [coord_w-1:0] width_m1;
    logic [coord_w-1:0] height_m1;

    logic               frame_active; // armed frame, window not yet passed
    logic               hact_d;
    logic [coord_w-1:0] line_cnt;     // index of current line
    logic [coord_w-1:0] pix_cnt;      // index of current pixel in line

    logic               line_start_w;
    logic               line_end_w;
    logic [coord_w:0]   bottom_w;     // last window line, one bit wider
    logic [coord_w:0]   right_w;      // last window pixel
    logic               in_v_w;
    logic               in_h_w;
    logic               done_w;
    logic [color_w-1:0] pix_color_w;

    assign line_start_w = hact_i && !hact_d;
    assign line_end_w   = !hact_i && hact_d;
    assign bottom_w     = {1'b0, top} + {1'b0, height_m1};
    assign right_w      = {1'b0, left} + {1'b0, width_m1};
    assign in_v_w       = (line_cnt >= top) && ({1'b0, line_cnt} <= bottom_w);
    assign in_h_w       = (pix_cnt >= left) && ({1'b0, pix_cnt} <= right_w);
    // first line below window, or a new frame cuts it short
    assign done_w = frame_active && (sof_i || (line_start_w && ({1'b0, line_cnt} > bottom_w)));
    // bit 0 flips per pixel, bit 1 per line
    assign pix_color_w = monochrome_i ? '0 :
                         {bayer_xor[1] ^ line_cnt[0], bayer_xor[0] ^ pix_cnt[0]};

    always_ff @(posedge pclk) begin
        if (cfg_we_i) begin
            if (cfg_addr_i == cfg_addr_left_top)     {top, left}           <= cfg_data_i;
            if (cfg_addr_i == cfg_addr_width_height) {height_m1, width_m1} <= cfg_data_i;
        end
    end

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            frame_active <= 1'b0;
            hact_d       <= 1'b0;
            line_cnt     <= '0;
            pix_cnt      <= '0;
            pix_valid_o  <= 1'b0;
            woi_done_o   <= 1'b0;
        end else begin
            hact_d     <= hact_i;
            woi_done_o <= done_w; // 1-cycle pulse

            if (done_w)                    frame_active <= 1'b0;
            else if (sof_i && frame_arm_i) frame_active <= 1'b1;

            if (sof_i && frame_arm_i)          line_cnt <= '0;
            else if (frame_active && line_end_w) line_cnt <= line_cnt + 1'b1;

            pix_cnt <= hact_i ? pix_cnt + 1'b1 : '0; // zero during blanking

            pix_valid_o <= frame_active && hact_i && in_v_w && in_h_w;
        end
    end

    // bin address follows the pixel by one cycle, aligned with pix_valid_o
    always_ff @(posedge pclk) begin
        pix_addr_o.fields.color <= pix_color_w;
        pix_addr_o.fields.pixel <= pixel_i;
    end

endmodule

// File: verilog/hist_accum.sv
//********************
// readout and pixel traffic never overlap; readout port wins if they do
//********************
module hist_accum
    import hist_bin_pkg::*;
(
    input  logic               pclk,
    input  logic               pix_valid_i,
    input  bin_addr_u          pix_addr_i,
    input  logic               rd_en_i,
    input  bin_addr_u          rd_addr_i,
    input  logic               clr_we_i,
    output logic [count_w-1:0] rd_data_o
);
    logic [count_w-1:0] mem [num_bins];

    // stage 2, read data returning
    logic               st2_valid;
    bin_addr_u          st2_addr;
    // stage 3, increment and write
    logic               st3_valid;
    bin_addr_u          st3_addr;
    logic [count_w-1:0] st3_base;     // count before this pixel
    // write retired last cycle, RAM read of that cycle missed it
    logic               wr_prev_valid;
    bin_addr_u          wr_prev_addr;
    logic [count_w-1:0] wr_prev_data;

    logic [bin_addr_w-1:0] rd_sel_w;
    logic [count_w-1:0]    inc_w;

    assign rd_sel_w = rd_en_i ? rd_addr_i.index : pix_addr_i.index;
    assign inc_w    = st3_base + 1'b1; // wraps, no saturation

    // read port, output reg holds while idle so readout data stays put
    always_ff @(posedge pclk) begin
        if (rd_en_i || pix_valid_i) rd_data_o <= mem[rd_sel_w];
    end

    // write port, zero on readout clear, else stage 3 result
    always_ff @(posedge pclk) begin
        if (clr_we_i)       mem[rd_addr_i.index] <= '0;
        else if (st3_valid) mem[st3_addr.index]  <= inc_w;
    end

    // stage 1 to 2
    always_ff @(posedge pclk) begin
        st2_valid <= pix_valid_i;
        st2_addr  <= pix_addr_i;
    end

    // stage 2 to 3, newest matching value wins
    always_ff @(posedge pclk) begin
        st3_valid <= st2_valid;
        st3_addr  <= st2_addr;
        if (st3_valid && st3_addr.index == st2_addr.index) begin
            st3_base <= inc_w;        // back-to-back same bin
        end else if (wr_prev_valid && wr_prev_addr.index == st2_addr.index) begin
            st3_base <= wr_prev_data; // one pixel in between
        end else begin
            st3_base <= rd_data_o;
        end
    end

    always_ff @(posedge pclk) begin
        wr_prev_valid <= st3_valid;
        wr_prev_addr  <= st3_addr;
        wr_prev_data  <= inc_w;
    end

endmodule

// File: verilog/hist_readout.sv
//********************
// two cycles per bin at best; data holds only while accumulator is idle
//********************
module hist_readout
    import hist_bin_pkg::*;
(
    input  logic               pclk,
    input  logic               hist_rst_pclk,
    input  logic               sweep_start_i,
    input  logic               sweep_emit_i,
    input  logic [count_w-1:0] rd_data_i,
    input  logic               bin_ready_i,
    output logic               rd_en_o,
    output bin_addr_u          rd_addr_o,
    output logic               clr_we_o,
    output logic [count_w-1:0] bin_data_o,
    output logic               bin_valid_o,
    output logic               sweep_done_o
);
    logic active;  // sweep in progress
    logic emit_q;  // 1 emit, 0 silent clear
    logic accept_w;
    logic step_w;
    logic last_w;

    assign accept_w = bin_valid_o && bin_ready_i;
    assign step_w   = active && (emit_q ? accept_w : 1'b1); // clear mode steps every cycle
    assign last_w   = (rd_addr_o.index == bin_addr_w'(num_bins - 1));

    assign rd_en_o    = active && emit_q && !bin_valid_o; // read, valid next cycle
    assign clr_we_o   = step_w;    // zero the bin once it is taken
    assign bin_data_o = rd_data_i; // RAM output reg is the data stage

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            active          <= 1'b0;
            emit_q          <= 1'b0;
            rd_addr_o.index <= '0;
            bin_valid_o     <= 1'b0;
            sweep_done_o    <= 1'b0;
        end else begin
            sweep_done_o <= step_w && last_w;

            if (sweep_start_i) begin
                active          <= 1'b1;
                emit_q          <= sweep_emit_i;
                rd_addr_o.index <= '0;
            end else if (step_w) begin
                if (last_w) active <= 1'b0;
                rd_addr_o.index <= rd_addr_o.index + 1'b1; // flat index walk
            end

            if (accept_w)     bin_valid_o <= 1'b0;
            else if (rd_en_o) bin_valid_o <= 1'b1;
        end
    end

endmodule

// File: verilog/hist_top.sv
//********************
// write the window before enabling; all ports on pclk
//********************
module hist_top
    import hist_geom_pkg::*;
    import hist_bin_pkg::*;
(
    input  logic                 pclk,
    input  logic                 hist_rst_pclk,
    input  logic                 sof_i,
    input  logic                 hact_i,
    input  logic [pixel_w-1:0]   pixel_i,
    input  logic                 cfg_we_i,
    input  logic                 cfg_addr_i,
    input  logic [2*coord_w-1:0] cfg_data_i,
    input  logic                 hist_en_i,
    input  logic                 monochrome_i,
    output logic [count_w-1:0]   bin_data_o,
    output logic                 bin_valid_o,
    input  logic                 bin_ready_i,
    output logic                 hist_busy_o
);
    logic               frame_arm;
    logic               woi_done;
    logic               pix_valid;
    bin_addr_u          pix_addr;
    logic               sweep_start;
    logic               sweep_emit;
    logic               sweep_done;
    logic               rd_en;
    bin_addr_u          rd_addr;
    logic               clr_we;
    logic [count_w-1:0] rd_data;

    hist_ctrl ctrl0 (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .hist_en_i     (hist_en_i),
        .sof_i         (sof_i),
        .woi_done_i    (woi_done),
        .sweep_done_i  (sweep_done),
        .frame_arm_o   (frame_arm),
        .sweep_start_o (sweep_start),
        .sweep_emit_o  (sweep_emit),
        .hist_busy_o   (hist_busy_o)
    );

    hist_window window0 (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .cfg_we_i      (cfg_we_i),
        .cfg_addr_i    (cfg_addr_i),
        .cfg_data_i    (cfg_data_i),
        .sof_i         (sof_i),
        .hact_i        (hact_i),
        .pixel_i       (pixel_i),
        .monochrome_i  (monochrome_i),
        .frame_arm_i   (frame_arm),
        .pix_valid_o   (pix_valid),
        .pix_addr_o    (pix_addr),
        .woi_done_o    (woi_done)
    );

    hist_accum accum0 (
        .pclk          (pclk),
        .pix_valid_i   (pix_valid),
        .pix_addr_i    (pix_addr),
        .rd_en_i       (rd_en),
        .rd_addr_i     (rd_addr),
        .clr_we_i      (clr_we),
        .rd_data_o     (rd_data)
    );

    hist_readout readout0 (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .sweep_start_i (sweep_start),
        .sweep_emit_i  (sweep_emit),
        .rd_data_i     (rd_data),
        .bin_ready_i   (bin_ready_i),
        .rd_en_o       (rd_en),
        .rd_addr_o     (rd_addr),
        .clr_we_o      (clr_we),
        .bin_data_o    (bin_data_o),
        .bin_valid_o   (bin_valid_o),
        .sweep_done_o  (sweep_done)
    );

endmodule

// File: testbench/hist_clkgen.sv
//********************
// 10 ns pclk, reset high from time 0 for 16 rising edges
//********************
module hist_clkgen (
    output logic pclk_o,
    output logic hist_rst_pclk_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        pclk_o = 1'b0;
        forever #5 pclk_o = ~pclk_o; // 100 MHz
    end

    initial begin
        hist_rst_pclk_o = 1'b1;
        repeat (16) @(posedge pclk_o);
        hist_rst_pclk_o <= 1'b0; // released on an edge, sync reset
    end

endmodule

// File: testbench/hist_properties.sv
//********************
// bin output handshake rules, bound into every hist_readout
//********************
module hist_properties
    import hist_bin_pkg::*;
(
    input logic               pclk,
    input logic               hist_rst_pclk,
    input logic               valid_i,
    input logic [count_w-1:0] data_i,
    input logic               ready_i,
    input logic               active_i,
    input logic               emit_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0; // failed checks so far

    // valid must be cleared by any reset cycle
    valid_low_in_reset: assert property (@(posedge pclk) hist_rst_pclk |=> !valid_i)
        else begin
            $error("bin_valid_o high after a reset cycle");
            fail_cnt++;
        end

    // stalled transfer keeps valid and data
    hold_under_stall: assert property (@(posedge pclk) disable iff (hist_rst_pclk)
        valid_i && !ready_i |=> valid_i && $stable(data_i))
        else begin
            $error("bin_valid_o or bin_data_o changed while stalled");
            fail_cnt++;
        end

    // silent clear sweep never presents a bin
    quiet_clear: assert property (@(posedge pclk) disable iff (hist_rst_pclk)
        active_i && !emit_i |-> !valid_i)
        else begin
            $error("bin_valid_o high during clear sweep");
            fail_cnt++;
        end

endmodule

bind hist_readout hist_properties props0 (
    .pclk          (pclk),
    .hist_rst_pclk (hist_rst_pclk),
    .valid_i       (bin_valid_o),
    .data_i        (bin_data_o),
    .ready_i       (bin_ready_i),
    .active_i      (active),
    .emit_i        (emit_q)
);

// File: testbench/tb_hist.sv
//********************
// frames need a line past the window bottom; ready pattern wraps every 4096 cycles
//********************
module tb_hist
    import hist_geom_pkg::*;
    import hist_bin_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int max_lines = 16;
    localparam int max_len   = 40;
    localparam int line_gap  = 6; // blanking between lines

    logic                 pclk;
    logic                 hist_rst_pclk;
    logic                 sof;
    logic                 hact;
    logic [pixel_w-1:0]   pixel;
    logic                 cfg_we;
    logic                 cfg_addr;
    logic [2*coord_w-1:0] cfg_data;
    logic                 hist_en;
    logic                 monochrome;
    logic [count_w-1:0]   bin_data;
    logic                 bin_valid;
    logic                 bin_ready;
    logic                 hist_busy;

    // stored frame and window, the reference works from these
    logic [pixel_w-1:0] frame_pix [max_lines][max_len];
    int                 n_lines;
    int                 line_len;
    int                 win_left;
    int                 win_top;
    int                 win_wm1;
    int                 win_hm1;
    bit                 mono_mode;

    logic [count_w-1:0] exp_bins [num_bins];
    logic [count_w-1:0] rx_bins [num_bins]; // accepted bins by index
    int                 rx_cnt;
    bit                 collecting;         // a readout is expected
    bit                 throttle;           // random back-pressure on
    bit                 ready_pat [4096];
    logic [11:0]        ready_idx;

    hist_clkgen clkgen0 (
        .pclk_o          (pclk),
        .hist_rst_pclk_o (hist_rst_pclk)
    );

    hist_top dut0 (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .sof_i         (sof),
        .hact_i        (hact),
        .pixel_i       (pixel),
        .cfg_we_i      (cfg_we),
        .cfg_addr_i    (cfg_addr),
        .cfg_data_i    (cfg_data),
        .hist_en_i     (hist_en),
        .monochrome_i  (monochrome),
        .bin_data_o    (bin_data),
        .bin_valid_o   (bin_valid),
        .bin_ready_i   (bin_ready),
        .hist_busy_o   (hist_busy)
    );

    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        stop_run();
    endtask

    task automatic compare_word(input string name, input logic [count_w-1:0] got,
                                input logic [count_w-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            stop_run();
        end
    endtask

    // count of window pixels that land in bin idx = {colour, pixel}
    function automatic logic [count_w-1:0] expected_count(input int idx);
        logic [count_w-1:0]    cnt;
        logic [color_w-1:0]    color;
        logic [bin_addr_w-1:0] bin;
        cnt = '0;
        for (int y = 0; y < n_lines; y++) begin
            for (int x = 0; x < line_len; x++) begin
                if (y >= win_top && y <= win_top + win_hm1 &&
                    x >= win_left && x <= win_left + win_wm1) begin
                    color = {bayer_xor[1] ^ y[0], bayer_xor[0] ^ x[0]}; // line, pixel phase
                    if (mono_mode) color = '0;
                    bin = {color, frame_pix[y][x]};
                    if (bin == idx) cnt++;
                end
            end
        end
        return cnt;
    endfunction

    task automatic make_frame(input int lines, input int len, input int range);
        n_lines  = lines;
        line_len = len;
        for (int y = 0; y < lines; y++) begin
            for (int x = 0; x < len; x++) frame_pix[y][x] = $urandom % range; // small range, repeats
        end
    endtask

    task automatic write_window(input int left, input int top, input int wm1, input int hm1);
        win_left = left;
        win_top  = top;
        win_wm1  = wm1;
        win_hm1  = hm1;
        @(posedge pclk);
        cfg_we   <= 1'b1;
        cfg_addr <= cfg_addr_left_top;
        cfg_data <= {coord_w'(top), coord_w'(left)};
        @(posedge pclk);
        cfg_addr <= cfg_addr_width_height;
        cfg_data <= {coord_w'(hm1), coord_w'(wm1)};
        @(posedge pclk);
        cfg_we   <= 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge pclk);
            sof   <= 1'b0;
            hact  <= 1'b0;
            pixel <= '0;
        end
    endtask

    task automatic send_frame();
        idle_cycles(4); // lets the FSM arm
        @(posedge pclk);
        sof <= 1'b1;
        idle_cycles(3);
        for (int y = 0; y < n_lines; y++) begin
            for (int x = 0; x < line_len; x++) begin
                @(posedge pclk);
                hact  <= 1'b1;
                pixel <= frame_pix[y][x];
            end
            idle_cycles(line_gap);
        end
    endtask

    task automatic wait_not_busy(input int limit);
        int n;
        n = 0;
        do begin
            @(posedge pclk);
            n++;
        end while (hist_busy && n < limit);
        if (hist_busy) abort_run("timeout waiting for hist_busy_o to fall");
    endtask

    task automatic wait_valid(input int limit);
        int n;
        n = 0;
        do begin
            @(posedge pclk);
            n++;
        end while (!bin_valid && n < limit);
        if (!bin_valid) abort_run("timeout waiting for the readout to start");
    endtask

    task automatic expect_readout();
        rx_cnt     = 0;
        collecting = 1'b1;
        for (int i = 0; i < num_bins; i++) exp_bins[i] = expected_count(i);
    endtask

    task automatic finish_readout();
        wait_not_busy(20000);
        collecting = 1'b0;
        compare_word("bin_valid_o transfer count", rx_cnt, num_bins);
    endtask

    // ready follows the seeded pattern only while throttling
    always @(posedge pclk) begin
        ready_idx <= ready_idx + 1'b1;
        bin_ready <= throttle ? ready_pat[ready_idx] : 1'b1;
    end

    // bound handshake assertions count their own failures
    always @(posedge pclk) begin
        if (dut0.readout0.props0.fail_cnt != 0) abort_run("a bin handshake assertion failed");
    end

    // comparing process, one bin per accepted transfer, flat order
    always @(posedge pclk) begin
        if (!hist_rst_pclk && bin_valid && bin_ready) begin
            if (!collecting || rx_cnt >= num_bins) begin
                abort_run("a bin was transferred while no readout was expected");
            end else begin
                rx_bins[rx_cnt] = bin_data;
                compare_word($sformatf("bin_data_o bin %0d", rx_cnt), rx_bins[rx_cnt],
                             exp_bins[rx_cnt]);
                if (mono_mode && rx_cnt >= 256) begin
                    compare_word($sformatf("bin_data_o mono bin %0d", rx_cnt), bin_data, '0);
                end
                rx_cnt++;
            end
        end
    end

    initial begin
        int n;
        sof        = 1'b0;
        hact       = 1'b0;
        pixel      = '0;
        cfg_we     = 1'b0;
        cfg_addr   = 1'b0;
        cfg_data   = '0;
        hist_en    = 1'b0;
        monochrome = 1'b0;
        bin_ready  = 1'b0;
        ready_idx  = '0;
        throttle   = 1'b0;
        collecting = 1'b0;
        mono_mode  = 1'b0;
        void'($urandom(32'hf349_0a0c));
        foreach (ready_pat[i]) ready_pat[i] = (($urandom % 5) < 3); // about 60% ready

        n = 0;
        do begin
            @(posedge pclk);
            n++;
        end while (hist_rst_pclk && n < 100);
        if (hist_rst_pclk) abort_run("reset was never released");
        wait_not_busy(1200); // clear sweep after reset

        // colour, window inside frame, ready high
        write_window(5, 3, 19, 7);
        @(posedge pclk);
        hist_en <= 1'b1;
        make_frame(14, 32, 256);
        expect_readout();
        send_frame();
        finish_readout();

        // monochrome
        mono_mode = 1'b1;
        @(posedge pclk);
        monochrome <= 1'b1;
        write_window(2, 1, 27, 10);
        make_frame(15, 32, 256);
        expect_readout();
        send_frame();
        finish_readout();

        // back-pressure, few pixel values so bins repeat back to back
        mono_mode = 1'b0;
        @(posedge pclk);
        monochrome <= 1'b0;
        throttle   <= 1'b1;
        write_window(0, 0, 35, 9);
        make_frame(12, 36, 6);
        expect_readout();
        send_frame();
        finish_readout();

        // two frames back to back, second one alone in its readout
        @(posedge pclk);
        throttle <= 1'b0;
        write_window(7, 2, 15, 8);
        make_frame(14, 32, 16);
        expect_readout();
        send_frame();
        finish_readout();
        make_frame(14, 32, 256);
        expect_readout();
        send_frame();
        finish_readout();

        // disabled at sof, nothing may come out
        @(posedge pclk);
        hist_en <= 1'b0;
        make_frame(14, 32, 256);
        send_frame();
        n = 0;
        do begin
            @(posedge pclk);
            n++;
            if (bin_valid) abort_run("a bin was emitted while hist_en_i was low");
        end while (n < 3000);

        // armed frame, then a sof during its readout that must be dropped
        @(posedge pclk);
        hist_en <= 1'b1;
        make_frame(14, 32, 256);
        expect_readout();
        send_frame();
        wait_valid(2000);
        if (!hist_busy) abort_run("hist_busy_o was low during the readout");
        make_frame(14, 32, 256); // reference already loaded
        send_frame();
        finish_readout();

        idle_cycles(10);
        if (dut0.readout0.props0.fail_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: vlog.f
verilog/hist_geom_pkg.sv
verilog/hist_bin_pkg.sv
verilog/hist_ctrl.sv
verilog/hist_window.sv
verilog/hist_accum.sv
verilog/hist_readout.sv
verilog/hist_top.sv
testbench/hist_clkgen.sv
testbench/hist_properties.sv
testbench/tb_hist.sv

// File: Bender.yml
package:
  name: pixel_hist

sources:
  - verilog/hist_geom_pkg.sv
  - verilog/hist_bin_pkg.sv
  - verilog/hist_ctrl.sv
  - verilog/hist_window.sv
  - verilog/hist_accum.sv
  - verilog/hist_readout.sv
  - verilog/hist_top.sv
  - target: test
    files:
      - testbench/hist_clkgen.sv
      - testbench/hist_properties.sv
      - testbench/tb_hist.sv
